// File: src/line_pkg.sv
package line_pkg;

    // bus and line geometry
    localparam int ADDR_BITS = 32;                      // byte address
    localparam int BEAT_BITS = 64;                      // one burst beat
    localparam int LINE_BITS = 256;                     // one cache line
    localparam int BEATS     = LINE_BITS / BEAT_BITS;   // beats per line

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // line arbiter grant state
    typedef enum logic [1:0] {
        ARB_IDLE,   // no grant, watching both ports
        ARB_IMEM,   // instruction port owns memory path
        ARB_DMEM    // data port owns memory path
    } arb_state_t;

    // burst adapter transfer state
    typedef enum logic [1:0] {
        AD_IDLE,        // waiting for line request and bmem ready
        AD_READ_WAIT,   // read command sent, collecting beats
        AD_WRITE,       // streaming write beats
        AD_RESP         // one-cycle line response
    } adapter_state_t;

endpackage : line_pkg

// File: src/line_req_if.sv
`timescale 1ns/1ps

// one line transfer channel between a requester and a responder
interface line_req_if;

    line_pkg::addr_t addr;      // line address
    logic            read;      // line read request
    logic            write;     // line write request
    line_pkg::line_t wdata;     // line to write
    line_pkg::line_t rdata;     // returned line, valid with resp
    logic            resp;      // one-cycle completion pulse

    // side that raises a request and holds it until resp
    modport requester (
        output addr,
        output read,
        output write,
        output wdata,
        input  rdata,
        input  resp
    );

    // side that services the request
    modport responder (
        input  addr,
        input  read,
        input  write,
        input  wdata,
        output rdata,
        output resp
    );

endinterface : line_req_if

// File: src/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter #(
    parameter int DATA_PRIORITY = 1     // nonzero: data port wins ties
) (
    input logic           clk,
    input logic           rst,
    line_req_if.responder i_port,
    line_req_if.responder d_port,
    line_req_if.requester mem_port
);

    line_pkg::arb_state_t state;
    line_pkg::arb_state_t state_next;

    logic i_req;
    logic d_req;

    assign i_req = i_port.read | i_port.write;
    assign d_req = d_port.read | d_port.write;

    // grant FSM, the grant is held until the memory side answers
    always_comb begin
        state_next = state;
        case (state)
            line_pkg::ARB_IDLE: begin
                if (d_req && (DATA_PRIORITY != 0 || !i_req)) begin
                    state_next = line_pkg::ARB_DMEM;
                end else if (i_req) begin
                    state_next = line_pkg::ARB_IMEM;
                end
            end
            line_pkg::ARB_IMEM,
            line_pkg::ARB_DMEM: begin
                if (mem_port.resp) begin
                    state_next = line_pkg::ARB_IDLE;    // rearbitrate next cycle
                end
            end
            default: begin
                state_next = line_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= line_pkg::ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // forward the granted port to the memory side
    always_comb begin
        mem_port.addr  = d_port.addr;
        mem_port.read  = 1'b0;      // nothing forwarded without a grant
        mem_port.write = 1'b0;
        mem_port.wdata = d_port.wdata;
        case (state)
            line_pkg::ARB_IMEM: begin
                mem_port.addr  = i_port.addr;
                mem_port.read  = i_port.read;
                mem_port.write = i_port.write;
                mem_port.wdata = i_port.wdata;
            end
            line_pkg::ARB_DMEM: begin
                mem_port.addr  = d_port.addr;
                mem_port.read  = d_port.read;
                mem_port.write = d_port.write;
                mem_port.wdata = d_port.wdata;
            end
            default: begin
                mem_port.read  = 1'b0;
                mem_port.write = 1'b0;
            end
        endcase
    end

    // line data is shared, only the owner sees resp
    assign i_port.rdata = mem_port.rdata;
    assign d_port.rdata = mem_port.rdata;
    assign i_port.resp  = mem_port.resp && (state == line_pkg::ARB_IMEM);
    assign d_port.resp  = mem_port.resp && (state == line_pkg::ARB_DMEM);

    // a single line can complete per transfer, so never both ports at once
    a_one_resp: assert property (
        @(posedge clk) disable iff (rst)
        !(i_port.resp && d_port.resp)
    ) else $error("line_arbiter: i_port and d_port resp high together");

endmodule : line_arbiter

// File: src/burst_adapter.sv
`timescale 1ns/1ps

module burst_adapter (
    input  logic            clk,
    input  logic            rst,
    line_req_if.responder   line_port,

    output line_pkg::addr_t bmem_addr_o,
    output logic            bmem_read_o,
    output logic            bmem_write_o,
    output line_pkg::beat_t bmem_wdata_o,
    input  logic            bmem_ready_i,

    input  line_pkg::addr_t bmem_raddr_i,
    input  line_pkg::beat_t bmem_rdata_i,
    input  logic            bmem_rvalid_i
);

    localparam int CNT_BITS = $clog2(line_pkg::BEATS);

    line_pkg::adapter_state_t state;
    line_pkg::adapter_state_t state_next;

    logic [CNT_BITS-1:0] beat_cnt;     // beat index within the line
    logic                last_beat;
    logic                accept_rd;
    logic                accept_wr;
    line_pkg::addr_t     addr_q;       // line address of the transfer
    line_pkg::line_t     line_q;       // read line assembly

    assign last_beat = (beat_cnt == CNT_BITS'(line_pkg::BEATS - 1));
    assign accept_rd = (state == line_pkg::AD_IDLE) && line_port.read && bmem_ready_i;
    assign accept_wr = (state == line_pkg::AD_IDLE) && line_port.write && bmem_ready_i;

    always_comb begin
        state_next = state;
        case (state)
            line_pkg::AD_IDLE: begin
                if (accept_rd) begin
                    state_next = line_pkg::AD_READ_WAIT;
                end else if (accept_wr) begin
                    state_next = line_pkg::AD_WRITE;
                end
            end
            line_pkg::AD_READ_WAIT: begin
                if (bmem_rvalid_i && last_beat) begin
                    state_next = line_pkg::AD_RESP;
                end
            end
            line_pkg::AD_WRITE: begin
                if (last_beat) begin
                    state_next = line_pkg::AD_RESP;
                end
            end
            default: begin
                state_next = line_pkg::AD_IDLE;     // resp done
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= line_pkg::AD_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == line_pkg::AD_IDLE) begin
                beat_cnt <= '0;
            end else if (state == line_pkg::AD_WRITE) begin
                beat_cnt <= beat_cnt + 1'b1;
            end else if (state == line_pkg::AD_READ_WAIT && bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept_rd || accept_wr) begin
            addr_q <= line_port.addr;
        end
        if (state == line_pkg::AD_READ_WAIT && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[line_pkg::LINE_BITS-1:line_pkg::BEAT_BITS]};
        end
    end

    // address is live in the accept cycle, then held from the latch
    assign bmem_addr_o  = (state == line_pkg::AD_IDLE) ? line_port.addr : addr_q;
    assign bmem_read_o  = accept_rd;
    assign bmem_write_o = (state == line_pkg::AD_WRITE);
    assign bmem_wdata_o = line_port.wdata[beat_cnt*line_pkg::BEAT_BITS +: line_pkg::BEAT_BITS];

    assign line_port.rdata = line_q;
    assign line_port.resp  = (state == line_pkg::AD_RESP);

    a_raddr_match: assert property (
        @(posedge clk) disable iff (rst)
        (state == line_pkg::AD_READ_WAIT && bmem_rvalid_i) |-> (bmem_raddr_i == addr_q)
    ) else $error("burst_adapter: bmem_raddr_i does not match line address");

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(bmem_read_o && bmem_write_o)
    ) else $error("burst_adapter: bmem read and write together");

    a_resp_pulse: assert property (
        @(posedge clk) disable iff (rst)
        line_port.resp |=> !line_port.resp
    ) else $error("burst_adapter: resp longer than one cycle");

endmodule : burst_adapter

// File: src/line_mem_bridge.sv
`timescale 1ns/1ps

module line_mem_bridge #(
    parameter int DATA_PRIORITY = 1     // data port wins ties by default
) (
    input  logic            clk,
    input  logic            rst,

    // instruction line port, read only
    input  line_pkg::addr_t i_addr_i,
    input  logic            i_read_i,
    output line_pkg::line_t i_rdata_o,
    output logic            i_resp_o,

    // data line port
    input  line_pkg::addr_t d_addr_i,
    input  logic            d_read_i,
    input  logic            d_write_i,
    input  line_pkg::line_t d_wdata_i,
    output line_pkg::line_t d_rdata_o,
    output logic            d_resp_o,

    // burst memory
    output line_pkg::addr_t bmem_addr_o,
    output logic            bmem_read_o,
    output logic            bmem_write_o,
    output line_pkg::beat_t bmem_wdata_o,
    input  logic            bmem_ready_i,
    input  line_pkg::addr_t bmem_raddr_i,
    input  line_pkg::beat_t bmem_rdata_i,
    input  logic            bmem_rvalid_i
);

    line_req_if i_port ();
    line_req_if d_port ();
    line_req_if mem_port ();

    assign i_port.addr  = i_addr_i;
    assign i_port.read  = i_read_i;
    assign i_port.write = 1'b0;         // fetch side never writes
    assign i_port.wdata = '0;
    assign i_rdata_o    = i_port.rdata;
    assign i_resp_o     = i_port.resp;

    assign d_port.addr  = d_addr_i;
    assign d_port.read  = d_read_i;
    assign d_port.write = d_write_i;
    assign d_port.wdata = d_wdata_i;
    assign d_rdata_o    = d_port.rdata;
    assign d_resp_o     = d_port.resp;

    line_arbiter #(
        .DATA_PRIORITY(DATA_PRIORITY)
    ) u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_port  (i_port.responder),
        .d_port  (d_port.responder),
        .mem_port(mem_port.requester)
    );

    burst_adapter u_adapter (
        .clk          (clk),
        .rst          (rst),
        .line_port    (mem_port.responder),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_raddr_i (bmem_raddr_i),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i)
    );

endmodule : line_mem_bridge

// File: verif/bmem_model.sv
`timescale 1ns/1ps

module bmem_model #(
    parameter int LINES = 64            // lines held, power of two
) (
    input  logic            clk,
    input  logic            rst,
    input  line_pkg::addr_t addr_i,
    input  logic            read_i,
    input  logic            write_i,
    input  line_pkg::beat_t wdata_i,
    output logic            ready_o,
    output line_pkg::addr_t raddr_o,
    output line_pkg::beat_t rdata_o,
    output logic            rvalid_o,
    output logic            err_o       // protocol violation seen
);

    localparam int OFFS_BITS = $clog2(line_pkg::LINE_BITS / 8);
    localparam int IDX_BITS  = $clog2(LINES);
    localparam int BEAT_W    = line_pkg::BEAT_BITS;

    line_pkg::line_t mem [LINES];       // filled by the testbench at time 0
    integer          seed;
    logic            rst_seen;
    logic            rd_busy;           // one line outstanding
    line_pkg::addr_t rd_addr;
    int              rd_cnt;
    int              wr_cnt;

    function automatic int line_index(input line_pkg::addr_t a);
        return int'(a[OFFS_BITS +: IDX_BITS]);
    endfunction

    initial begin
        seed     = 32'h08ab_9303;
        ready_o  = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
        rvalid_o = 1'b0;
        err_o    = 1'b0;
        rd_busy  = 1'b0;
        rd_addr  = '0;
        rd_cnt   = 0;
        wr_cnt   = 0;
    end

    always @(posedge clk) begin
        rst_seen = rst;                 // commands taken on the edge
        if (write_i) begin
            mem[line_index(addr_i)][wr_cnt*BEAT_W +: BEAT_W] = wdata_i;
            wr_cnt = wr_cnt + 1;
        end else begin
            wr_cnt = 0;
        end
        if (read_i && ready_o) begin
            rd_busy = 1'b1;
            rd_addr = addr_i;
            rd_cnt  = 0;
        end
        #1;
        rvalid_o = 1'b0;
        if (rst_seen) begin
            ready_o = 1'b0;
            rd_busy = 1'b0;
        end else begin
            ready_o = ($random(seed) & 3) != 0;     // low about one cycle in four
            if (rd_busy && (($random(seed) & 3) != 3)) begin
                rvalid_o = 1'b1;
                raddr_o  = rd_addr;
                rdata_o  = mem[line_index(rd_addr)][rd_cnt*BEAT_W +: BEAT_W];
                rd_cnt   = rd_cnt + 1;
                rd_busy  = (rd_cnt < line_pkg::BEATS);
            end
        end
    end

    a_read_ready: assert property (
        @(posedge clk) disable iff (rst)
        !ready_o |-> !read_i
    ) else begin
        $display("Error: read command while the burst memory was not ready at %0t", $time);
        err_o = 1'b1;
    end

    // a write burst starts only after a cycle with ready high
    a_write_ready: assert property (
        @(posedge clk) disable iff (rst)
        $rose(write_i) |-> $past(ready_o)
    ) else begin
        $display("Error: write burst started without ready at %0t", $time);
        err_o = 1'b1;
    end

    a_one_line: assert property (
        @(posedge clk) disable iff (rst)
        read_i |-> !rd_busy
    ) else begin
        $display("Error: new read while a line was still outstanding at %0t", $time);
        err_o = 1'b1;
    end

endmodule : bmem_model

// File: verif/tb_line_mem_bridge.sv
`timescale 1ns/1ps

module tb_line_mem_bridge;

    localparam int MEM_LINES = 64;
    localparam int TIMEOUT   = 200;     // cycles per wait

    logic            clk;
    logic            rst;
    line_pkg::addr_t i_addr;
    logic            i_read;
    line_pkg::line_t i_rdata;
    logic            i_resp;
    line_pkg::addr_t d_addr;
    logic            d_read;
    logic            d_write;
    line_pkg::line_t d_wdata;
    line_pkg::line_t d_rdata;
    logic            d_resp;
    line_pkg::addr_t bmem_addr;
    logic            bmem_read;
    logic            bmem_write;
    line_pkg::beat_t bmem_wdata;
    logic            bmem_ready;
    line_pkg::addr_t bmem_raddr;
    line_pkg::beat_t bmem_rdata;
    logic            bmem_rvalid;
    logic            bmem_err;

    line_pkg::line_t ref_mem [MEM_LINES];   // expected contents of the model
    integer          seed;

    line_mem_bridge UUT (
        .clk(clk), .rst(rst),
        .i_addr_i(i_addr), .i_read_i(i_read), .i_rdata_o(i_rdata), .i_resp_o(i_resp),
        .d_addr_i(d_addr), .d_read_i(d_read), .d_write_i(d_write), .d_wdata_i(d_wdata),
        .d_rdata_o(d_rdata), .d_resp_o(d_resp),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_wdata_o(bmem_wdata), .bmem_ready_i(bmem_ready), .bmem_raddr_i(bmem_raddr),
        .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid)
    );

    bmem_model #(.LINES(MEM_LINES)) u_bmem (
        .clk(clk), .rst(rst),
        .addr_i(bmem_addr), .read_i(bmem_read), .write_i(bmem_write), .wdata_i(bmem_wdata),
        .ready_o(bmem_ready), .raddr_o(bmem_raddr), .rdata_o(bmem_rdata),
        .rvalid_o(bmem_rvalid), .err_o(bmem_err)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic expect_line(input string name, input line_pkg::line_t exp,
                               input line_pkg::line_t act);
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    function automatic line_pkg::addr_t line_addr(input int l);
        return line_pkg::addr_t'(l * (line_pkg::LINE_BITS / 8));
    endfunction

    function automatic line_pkg::line_t pattern_line(input int l);
        line_pkg::line_t v;
        line_pkg::addr_t a;
        for (int k = 0; k < line_pkg::BEATS; k++) begin
            a = line_addr(l) + line_pkg::addr_t'(k * 8);
            v[k*line_pkg::BEAT_BITS +: line_pkg::BEAT_BITS] = {~a, a};  // tagged by byte address
        end
        return v;
    endfunction

    task automatic load_memories();
        for (int l = 0; l < MEM_LINES; l++) begin
            ref_mem[l] = pattern_line(l);
            u_bmem.mem[l] = pattern_line(l);
        end
    endtask

    task automatic random_line(output line_pkg::line_t v);
        for (int k = 0; k < line_pkg::LINE_BITS / 32; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
    endtask

    // returns at the falling edge inside the resp cycle
    task automatic wait_resp(input bit data_side, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!(data_side ? d_resp : i_resp)) begin
            if (n >= TIMEOUT) begin
                $display("Error: no %s within %0d cycles", name, TIMEOUT);
                stop_on_error();
            end
            @(negedge clk);
            n = n + 1;
        end
    endtask

    task automatic quiet_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            expect_bit("bmem_read_o", 1'b0, bmem_read);
            expect_bit("bmem_write_o", 1'b0, bmem_write);
            expect_bit("i_resp_o", 1'b0, i_resp);
            expect_bit("d_resp_o", 1'b0, d_resp);
        end
    endtask

    task automatic ifetch_line(input int l);
        @(posedge clk);
        #1;
        i_addr = line_addr(l);
        i_read = 1'b1;
        wait_resp(1'b0, "i_resp_o");
        expect_line("i_rdata_o", ref_mem[l], i_rdata);
        @(posedge clk);
        #1;
        i_read = 1'b0;
    endtask

    task automatic data_read(input int l);
        @(posedge clk);
        #1;
        d_addr = line_addr(l);
        d_read = 1'b1;
        wait_resp(1'b1, "d_resp_o");
        expect_line("d_rdata_o", ref_mem[l], d_rdata);
        @(posedge clk);
        #1;
        d_read = 1'b0;
    endtask

    task automatic data_write(input int l, input line_pkg::line_t v);
        @(posedge clk);
        #1;
        d_addr  = line_addr(l);
        d_wdata = v;
        d_write = 1'b1;
        wait_resp(1'b1, "d_resp_o");
        ref_mem[l] = v;
        @(posedge clk);
        #1;
        d_write = 1'b0;
    endtask

    // both ports raised together and the data side finishes first
    task automatic dual_read(input int il, input int dl);
        int n;
        @(posedge clk);
        #1;
        i_addr = line_addr(il);
        d_addr = line_addr(dl);
        i_read = 1'b1;
        d_read = 1'b1;
        n = 0;
        @(negedge clk);
        while (!i_resp && !d_resp) begin
            if (n >= TIMEOUT) begin
                $display("Error: no response to a dual read within %0d cycles", TIMEOUT);
                stop_on_error();
            end
            @(negedge clk);
            n = n + 1;
        end
        expect_bit("i_resp_o", 1'b0, i_resp);
        expect_bit("d_resp_o", 1'b1, d_resp);
        expect_line("d_rdata_o", ref_mem[dl], d_rdata);
        @(posedge clk);
        #1;
        d_read = 1'b0;
        wait_resp(1'b0, "i_resp_o");
        expect_line("i_rdata_o", ref_mem[il], i_rdata);
        @(posedge clk);
        #1;
        i_read = 1'b0;
    endtask

    a_i_pulse: assert property (@(posedge clk) disable iff (rst) i_resp |=> !i_resp)
        else begin
            $display("Fail at %0t ns: i_resp_o expected 0, got 1 after a resp cycle", $time);
            stop_on_error();
        end

    a_d_pulse: assert property (@(posedge clk) disable iff (rst) d_resp |=> !d_resp)
        else begin
            $display("Fail at %0t ns: d_resp_o expected 0, got 1 after a resp cycle", $time);
            stop_on_error();
        end

    a_resp_excl: assert property (@(posedge clk) disable iff (rst) !(i_resp && d_resp))
        else begin
            $display("Fail at %0t ns: d_resp_o expected 0, got 1 with i_resp_o high", $time);
            stop_on_error();
        end

    a_i_pending: assert property (@(posedge clk) disable iff (rst) i_resp |-> i_read)
        else begin
            $display("Error: i_resp_o high without a pending instruction read at %0t", $time);
            stop_on_error();
        end

    a_d_pending: assert property (@(posedge clk) disable iff (rst) d_resp |-> (d_read || d_write))
        else begin
            $display("Error: d_resp_o high without a pending data request at %0t", $time);
            stop_on_error();
        end

    a_bmem_proto: assert property (@(posedge clk) !bmem_err)
        else begin
            $display("Error: the burst memory model reported a protocol violation");
            stop_on_error();
        end

    initial begin
        line_pkg::line_t wline;
        int              pick;
        int              l;
        int              idx;
        seed      = 32'h08ab_9303;
        rst       = 1'b1;
        i_addr    = '0;
        i_read    = 1'b0;
        d_addr    = '0;
        d_read    = 1'b0;
        d_write   = 1'b0;
        d_wdata   = '0;
        load_memories();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        quiet_check(6);
        for (idx = 0; idx < 4; idx = idx + 1) begin
            ifetch_line(idx * 7 + 1);
        end
        random_line(wline);
        data_write(12, wline);
        data_read(12);
        data_read(11);      // neighbours keep old contents
        data_read(13);
        dual_read(20, 12);
        dual_read(12, 3);
        for (idx = 0; idx < 16; idx = idx + 1) begin
            pick = $random(seed) & 3;
            l    = int'($unsigned($random(seed)) % MEM_LINES);
            if (pick == 0) begin
                ifetch_line(l);
            end else if (pick == 1) begin
                data_read(l);
            end else begin
                random_line(wline);
                data_write(l, wline);
            end
        end
        quiet_check(4);
        $display("PASS: all tests");
        $finish;
    end

endmodule : tb_line_mem_bridge

// File: verilog.f
src/line_pkg.sv
src/line_req_if.sv
src/line_arbiter.sv
src/burst_adapter.sv
src/line_mem_bridge.sv
verif/bmem_model.sv
verif/tb_line_mem_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_mem_bridge -f verilog.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
